/* common/conv_macros.svh */
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Line geometry
`define CONV_TAPS        11
`define DATA_WIDTH       16
`define CONV_LINE_SIZE   (`CONV_TAPS * `DATA_WIDTH)

// Signed fixed-point accumulator
`define ACC_WIDTH        48
`define ACC_FRAC         16

// Line buffer, level counts 0 to depth
`define LINE_FIFO_DEPTH  4
`define LINE_LEVEL_WIDTH 3

// Host register port
`define AXIL_ADDR_WIDTH  8
`define AXIL_DATA_WIDTH  32

`define REG_DATA_BASE    8'h00
`define REG_WEIGHT_BASE  8'h40
`define REG_LAUNCH       8'h80
`define REG_STATUS       8'h84

`endif

/* common/fp16_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package fp16_pkg;

    localparam int EXP_BIAS   = 15;
    localparam int MANT_WIDTH = 10;

    // All-ones exponent, used for infinity
    localparam logic [4:0] EXP_MAX = 5'h1f;

    typedef struct packed {
        logic                  sign;
        logic [4:0]            exponent;
        logic [MANT_WIDTH-1:0] mantissa;
    } fp16_fields_t;

    // Same 16 bits seen as a raw word or as fields
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;
        fp16_fields_t           fields;
    } fp16_u;

    // Sum of products, ACC_FRAC fraction bits
    typedef logic signed [`ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

/* common/axil_pkg.sv */
`default_nettype none

`include "conv_macros.svh"

package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    typedef enum logic [2:0] {
        SEL_DATA_TAP,
        SEL_WEIGHT_TAP,
        SEL_LAUNCH,
        SEL_STATUS,
        SEL_INVALID
    } reg_sel_t;

    // Map a byte address onto its register class
    function automatic reg_sel_t decode_reg(input logic [`AXIL_ADDR_WIDTH-1:0] addr);
        logic [`AXIL_ADDR_WIDTH-1:0] data_off;
        logic [`AXIL_ADDR_WIDTH-1:0] weight_off;
        data_off   = addr - `REG_DATA_BASE;
        weight_off = addr - `REG_WEIGHT_BASE;
        if (addr == `REG_LAUNCH) return SEL_LAUNCH;
        if (addr == `REG_STATUS) return SEL_STATUS;
        if (addr[1:0] != 2'b00) return SEL_INVALID;
        if (data_off < 4 * `CONV_TAPS) return SEL_DATA_TAP;
        if (weight_off < 4 * `CONV_TAPS) return SEL_WEIGHT_TAP;
        return SEL_INVALID;
    endfunction

endpackage

`default_nettype wire

/* design/axil_line_loader.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module axil_line_loader (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [`AXIL_ADDR_WIDTH-1:0]      awaddr,
    input  wire                              awvalid,
    output logic                             awready,
    input  wire  [`AXIL_DATA_WIDTH-1:0]      wdata,
    input  wire  [`AXIL_DATA_WIDTH/8-1:0]    wstrb,
    input  wire                              wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  wire                              bready,
    input  wire  [`AXIL_ADDR_WIDTH-1:0]      araddr,
    input  wire                              arvalid,
    output logic                             arready,
    output logic [`AXIL_DATA_WIDTH-1:0]      rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  wire                              rready,
    output logic [`CONV_LINE_SIZE-1:0]       push_data,
    output logic [`CONV_LINE_SIZE-1:0]       push_weight,
    output logic                             push,
    input  wire                              full,
    input  wire  [`LINE_LEVEL_WIDTH-1:0]     level
);

    logic [`DATA_WIDTH-1:0]      data_tap   [`CONV_TAPS];
    logic [`DATA_WIDTH-1:0]      weight_tap [`CONV_TAPS];

    axil_pkg::reg_sel_t          wr_sel;
    axil_pkg::reg_sel_t          rd_sel;
    logic [3:0]                  wr_idx;
    logic [3:0]                  rd_idx;
    logic                        wr_fire;
    logic                        wr_ok;
    logic [`AXIL_DATA_WIDTH-1:0] rd_word;
    logic [1:0]                  rd_resp;

    //////////////////////////////////////////////////////////////////////
    // Write channels
    //////////////////////////////////////////////////////////////////////

    assign wr_sel = axil_pkg::decode_reg(awaddr);
    assign wr_idx = awaddr[5:2];

    // Partial strobes and the read-only status register are refused
    assign wr_ok = (wstrb == '1) && (wr_sel != axil_pkg::SEL_INVALID)
                   && (wr_sel != axil_pkg::SEL_STATUS);

    // AW and W are taken together; a launch waits for FIFO space
    assign awready = awvalid && wvalid && !bvalid
                     && !((wr_sel == axil_pkg::SEL_LAUNCH) && full);
    assign wready  = awready;
    assign wr_fire = awready;

    assign push = wr_fire && wr_ok && (wr_sel == axil_pkg::SEL_LAUNCH);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                data_tap[i]   <= '0;
                weight_tap[i] <= '0;
            end
        end else if (wr_fire && wr_ok) begin
            if (wr_sel == axil_pkg::SEL_DATA_TAP) begin
                data_tap[wr_idx] <= wdata[`DATA_WIDTH-1:0];
            end
            if (wr_sel == axil_pkg::SEL_WEIGHT_TAP) begin
                weight_tap[wr_idx] <= wdata[`DATA_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
    end

    // Tap 0 lands in the top word of the line
    always_comb begin
        for (int i = 0; i < `CONV_TAPS; i++) begin
            push_data[(`CONV_TAPS-1-i)*`DATA_WIDTH +: `DATA_WIDTH]   = data_tap[i];
            push_weight[(`CONV_TAPS-1-i)*`DATA_WIDTH +: `DATA_WIDTH] = weight_tap[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channels
    //////////////////////////////////////////////////////////////////////

    assign rd_sel  = axil_pkg::decode_reg(araddr);
    assign rd_idx  = araddr[5:2];
    assign arready = arvalid && !rvalid;

    always_comb begin
        rd_word = '0;
        rd_resp = axil_pkg::RESP_OKAY;
        case (rd_sel)
            axil_pkg::SEL_DATA_TAP:   rd_word[`DATA_WIDTH-1:0] = data_tap[rd_idx];
            axil_pkg::SEL_WEIGHT_TAP: rd_word[`DATA_WIDTH-1:0] = weight_tap[rd_idx];
            axil_pkg::SEL_STATUS:     rd_word[`LINE_LEVEL_WIDTH:0] = {full, level};
            // Launch is write only
            default:                  rd_resp = axil_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // Write response held until the host takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* design/line_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module line_fifo (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [`CONV_LINE_SIZE-1:0]    push_data,
    input  wire  [`CONV_LINE_SIZE-1:0]    push_weight,
    input  wire                           push,
    output logic                          full,
    output logic [`LINE_LEVEL_WIDTH-1:0]  level,
    output logic                          line_valid,
    output logic [`CONV_LINE_SIZE-1:0]    line_data,
    output logic [`CONV_LINE_SIZE-1:0]    line_weight,
    input  wire                           line_pop
);

    localparam int PTR_WIDTH = $clog2(`LINE_FIFO_DEPTH);

    logic [`CONV_LINE_SIZE-1:0]   data_mem   [`LINE_FIFO_DEPTH];
    logic [`CONV_LINE_SIZE-1:0]   weight_mem [`LINE_FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]         wr_ptr;
    logic [PTR_WIDTH-1:0]         rd_ptr;
    logic [`LINE_LEVEL_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr]   <= push_data;
            weight_mem[wr_ptr] <= push_weight;
        end
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (line_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push && !line_pop) begin
                count <= count + 1'b1;
            end else if (line_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full       = (count == `LINE_FIFO_DEPTH);
    assign level      = count;
    assign line_valid = (count != '0);

    // Show-ahead: head entry always on the outputs
    assign line_data   = data_mem[rd_ptr];
    assign line_weight = weight_mem[rd_ptr];

    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    assert property (@(posedge clk) disable iff (!rst_n) line_pop |-> line_valid);

endmodule

`default_nettype wire

/* mult_x11/fixed_to_fp16.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module fixed_to_fp16 (
    input  wire fp16_pkg::acc_t      sum,
    output logic [`DATA_WIDTH-1:0]   word
);

    // Integer part below 2^16 plus the fraction bits
    localparam int MAG_WIDTH = 16 + `ACC_FRAC;

    logic [`ACC_WIDTH-1:0]                 mag;
    logic [$clog2(MAG_WIDTH)-1:0]          lead;
    logic [MAG_WIDTH+fp16_pkg::MANT_WIDTH-1:0] norm;
    fp16_pkg::fp16_u                       fp;

    assign mag = sum[`ACC_WIDTH-1] ? -sum : sum;

    // Highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < MAG_WIDTH; i++) begin
            if (mag[i]) lead = i[$clog2(MAG_WIDTH)-1:0];
        end
    end

    // Leading one lands just above the mantissa field and lower bits drop
    assign norm = {mag[MAG_WIDTH-1:0], fp16_pkg::MANT_WIDTH'(0)} >> lead;

    always_comb begin
        fp.fields.sign = sum[`ACC_WIDTH-1];
        if (mag >= (`ACC_WIDTH'(1) << MAG_WIDTH)) begin
            fp.fields.exponent = fp16_pkg::EXP_MAX;
            fp.fields.mantissa = '0;
        end else if (lead < 2) begin
            // 2^-16 and 2^-15 are below the normal range
            fp.fields.exponent = '0;
            fp.fields.mantissa = {mag[1:0], 8'b0};
        end else begin
            fp.fields.exponent = 5'(lead + fp16_pkg::EXP_BIAS - `ACC_FRAC);
            fp.fields.mantissa = norm[fp16_pkg::MANT_WIDTH-1:0];
        end
    end

    assign word = fp.raw;

endmodule

`default_nettype wire

/* mult_x11/mult_x11.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module mult_x11 (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         line_valid,
    input  wire  [`CONV_LINE_SIZE-1:0]  line_data,
    input  wire  [`CONV_LINE_SIZE-1:0]  line_weight,
    output logic                        line_pop,
    output logic [`DATA_WIDTH-1:0]      result,
    output logic                        result_valid,
    input  wire                         result_ready
);

    // Raw mantissa product carries 2^-(2*bias + 2*10); keep ACC_FRAC of it
    localparam int PROD_SHIFT = 2 * fp16_pkg::EXP_BIAS + 2 * fp16_pkg::MANT_WIDTH
                                - `ACC_FRAC;

    fp16_pkg::acc_t         prod_s1 [`CONV_TAPS];
    logic                   valid_s1;
    fp16_pkg::acc_t         sum_s2;
    logic                   valid_s2;
    fp16_pkg::acc_t         sum_tree;
    logic [`DATA_WIDTH-1:0] conv_word;
    logic                   advance;

    function automatic fp16_pkg::acc_t tap_product(input fp16_pkg::fp16_u a,
                                                   input fp16_pkg::fp16_u b);
        logic [2*fp16_pkg::MANT_WIDTH+1:0] prod;
        logic [6:0]                        exp_sum;
        logic [`ACC_WIDTH-1:0]             mag;
        prod    = {1'b1, a.fields.mantissa} * {1'b1, b.fields.mantissa};
        exp_sum = 7'(a.fields.exponent) + 7'(b.fields.exponent);
        if (exp_sum >= PROD_SHIFT) begin
            mag = `ACC_WIDTH'(prod) << (exp_sum - PROD_SHIFT);
        end else begin
            mag = `ACC_WIDTH'(prod) >> (PROD_SHIFT - exp_sum);
        end
        // Subnormal taps count as zero
        if (a.fields.exponent == '0 || b.fields.exponent == '0) begin
            mag = '0;
        end
        return (a.fields.sign ^ b.fields.sign) ? -fp16_pkg::acc_t'(mag)
                                               : fp16_pkg::acc_t'(mag);
    endfunction

    // Whole pipeline moves only when the output slot frees up
    assign advance  = !result_valid || result_ready;
    assign line_pop = line_valid && advance;

    //////////////////////////////////////////////////////////////////////
    // Stage 1, tap products
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                prod_s1[i] <= tap_product(
                    line_data[(`CONV_TAPS-1-i)*`DATA_WIDTH +: `DATA_WIDTH],
                    line_weight[(`CONV_TAPS-1-i)*`DATA_WIDTH +: `DATA_WIDTH]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2, adder tree
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_tree = '0;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            sum_tree = sum_tree + prod_s1[i];
        end
    end

    always_ff @(posedge clk) begin
        if (advance) sum_s2 <= sum_tree;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 3, back to FP16
    //////////////////////////////////////////////////////////////////////

    fixed_to_fp16 u_fixed_to_fp16 (
        .sum  (sum_s2),
        .word (conv_word)
    );

    always_ff @(posedge clk) begin
        if (advance) result <= conv_word;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1     <= 1'b0;
            valid_s2     <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            valid_s1     <= line_valid;
            valid_s2     <= valid_s1;
            result_valid <= valid_s2;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

`default_nettype wire

/* design/conv_x11_top.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module conv_x11_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [`AXIL_ADDR_WIDTH-1:0]   awaddr,
    input  wire                           awvalid,
    output logic                          awready,
    input  wire  [`AXIL_DATA_WIDTH-1:0]   wdata,
    input  wire  [`AXIL_DATA_WIDTH/8-1:0] wstrb,
    input  wire                           wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  wire                           bready,
    input  wire  [`AXIL_ADDR_WIDTH-1:0]   araddr,
    input  wire                           arvalid,
    output logic                          arready,
    output logic [`AXIL_DATA_WIDTH-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  wire                           rready,
    output logic [`DATA_WIDTH-1:0]        result,
    output logic                          result_valid,
    input  wire                           result_ready
);

    logic [`CONV_LINE_SIZE-1:0]   push_data;
    logic [`CONV_LINE_SIZE-1:0]   push_weight;
    logic                         push;
    logic                         full;
    logic [`LINE_LEVEL_WIDTH-1:0] level;
    logic                         line_valid;
    logic [`CONV_LINE_SIZE-1:0]   line_data;
    logic [`CONV_LINE_SIZE-1:0]   line_weight;
    logic                         line_pop;

    axil_line_loader u_axil_line_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .push_data   (push_data),
        .push_weight (push_weight),
        .push        (push),
        .full        (full),
        .level       (level)
    );

    line_fifo u_line_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_data   (push_data),
        .push_weight (push_weight),
        .push        (push),
        .full        (full),
        .level       (level),
        .line_valid  (line_valid),
        .line_data   (line_data),
        .line_weight (line_weight),
        .line_pop    (line_pop)
    );

    mult_x11 u_mult_x11 (
        .clk          (clk),
        .rst_n        (rst_n),
        .line_valid   (line_valid),
        .line_data    (line_data),
        .line_weight  (line_weight),
        .line_pop     (line_pop),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

/* tests/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// AXI4-Lite host side drives on rising edges and samples on falling edges

task automatic start_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    @(negedge clk);
endtask

// Called at a falling edge; waits for AW/W, then takes the B response
task automatic finish_write(output logic [1:0] resp);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(negedge clk); while (!bvalid);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
endtask

task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    start_write(addr, data);
    finish_write(resp);
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do @(negedge clk); while (!arready);
    @(posedge clk);
    arvalid <= 1'b0;
    do @(negedge clk); while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
endtask

// FP16 encoding with truncation toward zero
function automatic logic [15:0] fp16_encode(input real value);
    logic sign;
    real  mag;
    real  scale;
    int   e;
    sign = (value < 0.0);
    mag  = sign ? -value : value;
    if (mag == 0.0) return 16'h0000;
    if (mag >= 65536.0) return {sign, 15'h7c00};
    scale = 1.0 / 16384.0;
    // Subnormal range in steps of 2^-24
    if (mag < scale) return {sign, 5'd0, 10'($rtoi(mag * 16777216.0))};
    e = -14;
    while (mag >= 2.0 * scale) begin
        scale = 2.0 * scale;
        e++;
    end
    return {sign, 5'(e + 15), 10'($rtoi((mag / scale - 1.0) * 1024.0))};
endfunction

`endif

/* tests/tb_conv_x11.sv */
`default_nettype none
`timescale 1ns/100ps

`include "conv_macros.svh"

module tb_conv_x11;

    localparam int RANDOM_LINES = 40;
    localparam int MAX_FILL     = 12;
    localparam int MAX_LINES    = 3 + RANDOM_LINES + MAX_FILL;
    localparam int CYCLE_LIMIT  = 200 * MAX_LINES + 1000;

    logic                          clk;
    logic                          rst_n;
    logic [`AXIL_ADDR_WIDTH-1:0]   awaddr;
    logic                          awvalid;
    logic                          awready;
    logic [`AXIL_DATA_WIDTH-1:0]   wdata;
    logic [`AXIL_DATA_WIDTH/8-1:0] wstrb;
    logic                          wvalid;
    logic                          wready;
    logic [1:0]                    bresp;
    logic                          bvalid;
    logic                          bready;
    logic [`AXIL_ADDR_WIDTH-1:0]   araddr;
    logic                          arvalid;
    logic                          arready;
    logic [`AXIL_DATA_WIDTH-1:0]   rdata;
    logic [1:0]                    rresp;
    logic                          rvalid;
    logic                          rready;
    logic [`DATA_WIDTH-1:0]        result;
    logic                          result_valid;
    logic                          result_ready;

    integer                        seed;
    int                            cycles = 0;
    string                         test_name;
    logic                          rand_ready;
    logic [15:0]                   expected_q [$];
    logic [15:0]                   tap_shadow [2*`CONV_TAPS];
    real                           data_val   [`CONV_TAPS];
    real                           weight_val [`CONV_TAPS];
    real                           known_data [`CONV_TAPS];
    logic [7:0]                    bad_addr   [7];

    conv_x11_top u_conv_x11_top (
        .clk (clk), .rst_n (rst_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .result (result), .result_valid (result_valid), .result_ready (result_ready)
    );

    `include "tb_axil_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] tap_addr(input int idx);
        if (idx < `CONV_TAPS) return 8'(`REG_DATA_BASE + 4 * idx);
        return 8'(`REG_WEIGHT_BASE + 4 * (idx - `CONV_TAPS));
    endfunction

    task automatic write_tap(input int idx, input logic [31:0] value);
        logic [1:0] resp;
        axil_write(tap_addr(idx), value, resp);
        check_value({test_name, " tap write"}, axil_pkg::RESP_OKAY, resp);
        tap_shadow[idx] = value[15:0];
    endtask

    // Taps are multiples of 0.5 in -8..8, so every product is exact
    task automatic randomize_line();
        for (int i = 0; i < `CONV_TAPS; i++) begin
            data_val[i]   = 0.5 * ($random(seed) % 17);
            weight_val[i] = 0.5 * ($random(seed) % 17);
        end
    endtask

    task automatic load_line();
        for (int i = 0; i < `CONV_TAPS; i++) begin
            write_tap(i, {16'h0, fp16_encode(data_val[i])});
            write_tap(`CONV_TAPS + i, {16'h0, fp16_encode(weight_val[i])});
        end
    endtask

    function automatic logic [15:0] model_value();
        real sum;
        sum = 0.0;
        for (int i = 0; i < `CONV_TAPS; i++) begin
            sum = sum + data_val[i] * weight_val[i];
        end
        return fp16_encode(sum);
    endfunction

    task automatic launch_line(input logic [15:0] expected);
        logic [1:0] resp;
        expected_q.push_back(expected);
        axil_write(`REG_LAUNCH, 32'h0, resp);
        check_value({test_name, " launch"}, axil_pkg::RESP_OKAY, resp);
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) @(posedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Result monitor, random ready and timeout
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && result_valid && result_ready) begin
            if (expected_q.size() == 0)
                stop_with_error("A result arrived with no launched line waiting for it");
            else
                check_value({test_name, " result"}, expected_q.pop_front(), result);
        end
    end

    always @(posedge clk) begin
        if (rand_ready) result_ready <= 1'($random(seed));
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            stop_with_error($sformatf("Timeout after %0d cycles", cycles));
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic [1:0]  resp;
        logic [31:0] value;
        logic        stalled;
        int          idx;
        int          waits;

        seed         = 32'h6cbe_2d8b;
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        result_ready = 1'b1;
        rand_ready   = 1'b0;
        known_data   = '{1.0, 1.5, 1.5, 2.0, 2.0, 2.0, 2.0, 2.5, 2.5, 2.5, 2.5};
        bad_addr     = '{8'h2c, 8'h3c, 8'h6c, 8'h7c, 8'h88, 8'hfc, 8'h41};
        for (int i = 0; i < 2 * `CONV_TAPS; i++) tap_shadow[i] = 16'h0;

        test_name = "reset_state";
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("reset_state in reset", 32'h0, {result_valid, bvalid, rvalid});
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_state after reset", 32'h0, {result_valid, bvalid, rvalid});
        axil_read(`REG_STATUS, rd, resp);
        check_value("reset_state status", 32'h0, rd);

        // Alternating sum of the data is 1 and the plain sum is 22
        test_name = "known_lines";
        for (int i = 0; i < `CONV_TAPS; i++) begin
            data_val[i]   = known_data[i];
            weight_val[i] = (i % 2 == 0) ? 1.0 : -1.0;
        end
        load_line();
        launch_line(16'h3c00);
        for (int i = 0; i < `CONV_TAPS; i++) weight_val[i] = -1.0;
        load_line();
        launch_line(16'hcd80);
        for (int i = 0; i < `CONV_TAPS; i++) begin
            data_val[i]   = -known_data[i];
            weight_val[i] = (i % 2 == 0) ? 1.0 : -1.0;
        end
        load_line();
        launch_line(16'hbc00);
        wait_drain();

        test_name = "random_lines";
        repeat (RANDOM_LINES) begin
            randomize_line();
            load_line();
            launch_line(model_value());
        end
        wait_drain();

        // One line waits at the output and four fill the FIFO before a launch stalls
        test_name = "back_pressure";
        @(posedge clk);
        result_ready <= 1'b0;
        stalled = 1'b0;
        for (int n = 0; n < MAX_FILL && !stalled; n++) begin
            randomize_line();
            load_line();
            expected_q.push_back(model_value());
            start_write(`REG_LAUNCH, 32'h0);
            for (waits = 0; waits < 8 && !(awready && wready); waits++) @(negedge clk);
            if (awready && wready) begin
                finish_write(resp);
                check_value("back_pressure launch", axil_pkg::RESP_OKAY, resp);
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled) stop_with_error("Launch writes never stalled with results held back");
        axil_read(`REG_STATUS, rd, resp);
        check_value("back_pressure status", 32'h0000_000c, rd);
        @(negedge clk);
        rand_ready = 1'b1;
        finish_write(resp);
        check_value("back_pressure stalled launch", axil_pkg::RESP_OKAY, resp);
        wait_drain();
        @(negedge clk);
        rand_ready = 1'b0;
        @(posedge clk);
        result_ready <= 1'b1;

        test_name = "register_access";
        repeat (16) begin
            idx   = $unsigned($random(seed)) % (2 * `CONV_TAPS);
            value = $random(seed);
            write_tap(idx, value);
            axil_read(tap_addr(idx), rd, resp);
            check_value("register_access readback", {16'h0, tap_shadow[idx]}, rd);
        end
        for (int i = 0; i < 7; i++) begin
            axil_write(bad_addr[i], 32'hffff_ffff, resp);
            check_value("register_access bad write", axil_pkg::RESP_SLVERR, resp);
            axil_read(bad_addr[i], rd, resp);
            check_value("register_access bad read", axil_pkg::RESP_SLVERR, resp);
        end
        for (int i = 0; i < 2 * `CONV_TAPS; i++) begin
            axil_read(tap_addr(i), rd, resp);
            check_value("register_access tap unchanged", {16'h0, tap_shadow[i]}, rd);
        end

        repeat (10) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
+incdir+tests
common/fp16_pkg.sv
common/axil_pkg.sv
design/axil_line_loader.sv
design/line_fifo.sv
mult_x11/fixed_to_fp16.sv
mult_x11/mult_x11.sv
design/conv_x11_top.sv
tests/tb_conv_x11.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_x11 \
    -f all.f \
    -o sim_conv_x11

# The log is searched below, so a failing run must not stop the script here
./obj_dir/sim_conv_x11 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
